/* hdl/conv_pkg.sv */
// Widths, kernel geometry and the data and accumulator types of the convolution engine
package conv_pkg;

    // Pixels and weights are signed 8-bit integers
    localparam int DATA_WIDTH = 8;

    // Nine 8x8 products need 16 + 4 bits
    localparam int ACC_WIDTH  = 20;

    localparam int KERNEL     = 3;                  // 3x3 kernel
    localparam int BAND_WIDTH = KERNEL * KERNEL;    // One lane per kernel tap

    // Input side of up to 16 pixels
    localparam int SRAM_DEPTH = 256;
    localparam int ADDR_WIDTH = $clog2(SRAM_DEPTH);

    // Output map side, 1 to 14
    localparam int SIZE_WIDTH = 4;

    typedef logic signed [DATA_WIDTH-1:0] data_t;
    typedef logic signed [ACC_WIDTH-1:0]  acc_t;

endpackage

/* hdl/conv_ifs.sv */
// Interfaces bank_rd_if and skew_if with their modports
`timescale 1ns/1ns

// Per-lane read port bundle of the feature-map bank
interface bank_rd_if #(
    parameter int BAND_WIDTH = conv_pkg::BAND_WIDTH,
    parameter int ADDR_WIDTH = conv_pkg::ADDR_WIDTH
);
    logic [BAND_WIDTH-1:0] rd_en;
    logic [ADDR_WIDTH-1:0] rd_addr [BAND_WIDTH];
    conv_pkg::data_t       rd_data [BAND_WIDTH];  // One cycle after rd_en

    modport client (
        output rd_en,
        output rd_addr,
        input  rd_data
    );

    modport server (
        input  rd_en,
        input  rd_addr,
        output rd_data
    );
endinterface

// Skewed lane delivery from data setup to the MAC chain
interface skew_if #(
    parameter int BAND_WIDTH = conv_pkg::BAND_WIDTH
);
    logic [BAND_WIDTH-1:0] lane_valid;
    conv_pkg::data_t       lane_data [BAND_WIDTH];
    logic                  last;       // Travels with the last lane's valid
    logic                  advance;    // Pipeline moves only when high

    modport src (
        output lane_valid,
        output lane_data,
        output last,
        input  advance
    );

    modport snk (
        input  lane_valid,
        input  lane_data,
        input  last,
        output advance
    );
endinterface

/* hdl/ifmap_bank.sv */
// Feature-map bank: replicated memories with a shared write port and per-lane read ports
`timescale 1ns/1ns

module ifmap_bank #(
    parameter int SRAM_DEPTH = 256,
    parameter int BAND_WIDTH = 9
) (
    input  logic                          clk,
    input  logic                          rst,

    input  logic                          wr_en_i,
    input  logic [$clog2(SRAM_DEPTH)-1:0] wr_addr_i,
    input  conv_pkg::data_t               wr_data_i,

    bank_rd_if.server                     rd
);

    // Every lane gets a private copy so all nine taps read in one cycle
    for (genvar k = 0; k < BAND_WIDTH; k++) begin : g_copy
        conv_pkg::data_t mem [SRAM_DEPTH];

        always_ff @(posedge clk) begin
            if (wr_en_i) begin
                mem[wr_addr_i] <= wr_data_i;   // Broadcast to all copies
            end
        end

        // Registered read, output holds while the lane is idle
        always_ff @(posedge clk) begin
            if (rd.rd_en[k]) begin
                rd.rd_data[k] <= mem[rd.rd_addr[k]];
            end
        end

        // Address chain from data setup must stay inside the map
        a_addr_range : assert property (
            @(posedge clk) disable iff (rst)
            rd.rd_en[k] |-> (rd.rd_addr[k] < SRAM_DEPTH)
        ) else $error("lane %0d read address %0d out of range", k, rd.rd_addr[k]);
    end

endmodule

/* hdl/data_setup.sv */
// Data setup: output-window counters, skewed address chain, lane valid/data and last marking
`timescale 1ns/1ns

module data_setup #(
    parameter int SRAM_DEPTH = 256,
    parameter int BAND_WIDTH = 9
) (
    input  logic                            clk,
    input  logic                            rst,

    input  logic                            start_i,
    input  logic [conv_pkg::SIZE_WIDTH-1:0] ofmap_size_i,
    output logic                            busy_o,

    bank_rd_if.client                       rd,
    skew_if.src                             sa
);

    localparam int AW = $clog2(SRAM_DEPTH);
    localparam int SW = conv_pkg::SIZE_WIDTH;

    logic [SW-1:0]         size_q;
    logic [SW:0]           in_side;      // n = output size + 2
    logic [2*SW-1:0]       win_total;
    logic [SW-1:0]         col;
    logic [AW-1:0]         row_base;
    logic [2*SW-1:0]       win_cnt;
    logic                  busy;
    logic                  issuing;      // Windows still to be issued
    logic                  issue_last;
    logic                  advance;

    logic [AW-1:0]         addr_q [BAND_WIDTH];
    logic [BAND_WIDTH-1:0] en_q;         // Read enables, one lane further per cycle
    logic [BAND_WIDTH-1:0] last_sh;
    logic [BAND_WIDTH-1:0] vld_n;        // Valid delayed for read latency
    logic                  last_n;
    logic [BAND_WIDTH-1:0] lane_valid_q;
    conv_pkg::data_t       lane_data_q [BAND_WIDTH];
    logic                  last_q;
    logic [1:0]            drain;        // Last result in PE 8 reg, then in output reg

    assign advance    = sa.advance;
    assign in_side    = (SW + 1)'(size_q) + (SW + 1)'(2);
    assign win_total  = size_q * size_q;
    assign issue_last = (win_cnt == win_total - 1'b1);

    // Window stepping across the output map, row-major
    always_ff @(posedge clk) begin
        if (rst) begin
            size_q   <= '0;
            busy     <= 1'b0;
            issuing  <= 1'b0;
            col      <= '0;
            row_base <= '0;
            win_cnt  <= '0;
        end else begin
            if (start_i && !busy) begin
                size_q   <= ofmap_size_i;
                busy     <= 1'b1;
                issuing  <= 1'b1;
                col      <= '0;
                row_base <= '0;
                win_cnt  <= '0;
            end else if (advance && issuing) begin
                win_cnt <= win_cnt + 1'b1;
                if (col == size_q - 1'b1) begin
                    col      <= '0;
                    row_base <= row_base + AW'(in_side);   // Next input row
                end else begin
                    col <= col + 1'b1;
                end
                if (issue_last) begin
                    issuing <= 1'b0;
                end
            end

            // Final result accepted at the output register
            if (advance && drain[1]) begin
                busy <= 1'b0;
            end
        end
    end

    // Control side of the skewed lane pipeline
    always_ff @(posedge clk) begin
        if (rst) begin
            en_q         <= '0;
            last_sh      <= '0;
            vld_n        <= '0;
            last_n       <= 1'b0;
            lane_valid_q <= '0;
            last_q       <= 1'b0;
            drain        <= '0;
        end else if (advance) begin
            en_q         <= {en_q[BAND_WIDTH-2:0], issuing};
            last_sh      <= {last_sh[BAND_WIDTH-2:0], issuing && issue_last};
            vld_n        <= en_q;
            last_n       <= last_sh[BAND_WIDTH-1];
            lane_valid_q <= vld_n;
            last_q       <= last_n;
            drain        <= {drain[0], last_q};
        end
    end

    // Address chain and captured lane data
    always_ff @(posedge clk) begin
        if (advance) begin
            addr_q[0] <= row_base + AW'(col);
            for (int k = 1; k < BAND_WIDTH; k++) begin
                if (k % conv_pkg::KERNEL == 0) begin
                    addr_q[k] <= addr_q[k-1] + AW'(size_q);   // Wrap to next kernel row
                end else begin
                    addr_q[k] <= addr_q[k-1] + 1'b1;
                end
            end
            for (int k = 0; k < BAND_WIDTH; k++) begin
                if (vld_n[k]) begin
                    lane_data_q[k] <= rd.rd_data[k];
                end
            end
        end
    end

    // Bank must not read during a stall, its output then holds
    assign rd.rd_en      = en_q & {BAND_WIDTH{advance}};
    assign rd.rd_addr    = addr_q;
    assign sa.lane_valid = lane_valid_q;
    assign sa.lane_data  = lane_data_q;
    assign sa.last       = last_q;
    assign busy_o        = busy;

    // Each window walks down the lanes one cycle per lane
    for (genvar k = 1; k < BAND_WIDTH; k++) begin : g_skew_chk
        a_diagonal : assert property (
            @(posedge clk) disable iff (rst)
            advance && sa.lane_valid[k-1] |=> sa.lane_valid[k]
        ) else $error("lane %0d valid did not follow lane %0d", k, k - 1);
    end

endmodule

/* hdl/mac_pe.sv */
// Weight-stationary processing element: multiply-add with registered partial sum
`timescale 1ns/1ns

module mac_pe (
    input  logic            clk,
    input  logic            rst,
    input  logic            en_i,        // Pipeline advance
    input  logic            w_load_i,
    input  conv_pkg::data_t w_i,
    input  logic            x_valid_i,
    input  conv_pkg::data_t x_i,
    input  conv_pkg::acc_t  psum_i,
    output conv_pkg::acc_t  psum_o,
    output logic            valid_o
);

    conv_pkg::data_t weight;   // Stationary for a whole frame

    always_ff @(posedge clk) begin
        if (w_load_i) begin
            weight <= w_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_o <= 1'b0;
        end else if (en_i) begin
            valid_o <= x_valid_i;
        end
    end

    // Operands are sign-extended to the accumulator width
    always_ff @(posedge clk) begin
        if (en_i) begin
            psum_o <= psum_i + weight * x_i;
        end
    end

endmodule

/* hdl/mac_chain.sv */
// Weight load, nine chained PEs, output register and pipeline advance of the MAC chain
`timescale 1ns/1ns

module mac_chain #(
    parameter int BAND_WIDTH = 9
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            busy_i,

    input  logic            w_valid_i,
    input  conv_pkg::data_t w_data_i,
    output logic            w_ready_o,

    skew_if.snk             sa,

    output logic            result_valid_o,
    output conv_pkg::acc_t  result_data_o,
    input  logic            result_ready_i,
    output logic            frame_done_o
);

    localparam int IW = $clog2(BAND_WIDTH);

    logic [IW-1:0]         w_idx;      // Next PE to take a weight
    logic                  w_fire;
    logic                  advance;
    conv_pkg::acc_t        psum_chain [BAND_WIDTH+1];
    logic [BAND_WIDTH-1:0] pe_valid;
    logic                  last_q;     // Marker beside the last PE's sum
    logic                  out_valid;
    logic                  out_last;
    conv_pkg::acc_t        out_data;

    assign w_ready_o      = !busy_i;
    assign w_fire         = w_valid_i && w_ready_o;
    assign advance        = !out_valid || result_ready_i;
    assign sa.advance     = advance;
    assign psum_chain[0]  = '0;

    // Weight index 0 goes first and restarts at every frame
    always_ff @(posedge clk) begin
        if (rst) begin
            w_idx <= '0;
        end else if (busy_i) begin
            w_idx <= '0;
        end else if (w_fire) begin
            w_idx <= (w_idx == IW'(BAND_WIDTH - 1)) ? '0 : w_idx + 1'b1;
        end
    end

    for (genvar k = 0; k < BAND_WIDTH; k++) begin : g_pe
        mac_pe i_pe (
            .clk       (clk),
            .rst       (rst),
            .en_i      (advance),
            .w_load_i  (w_fire && (w_idx == IW'(k))),
            .w_i       (w_data_i),
            .x_valid_i (sa.lane_valid[k]),
            .x_i       (sa.lane_data[k]),
            .psum_i    (psum_chain[k]),
            .psum_o    (psum_chain[k+1]),
            .valid_o   (pe_valid[k])
        );
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            last_q    <= 1'b0;
            out_valid <= 1'b0;
            out_last  <= 1'b0;
        end else if (advance) begin
            last_q    <= sa.last;
            out_valid <= pe_valid[BAND_WIDTH-1];
            out_last  <= last_q;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            out_data <= psum_chain[BAND_WIDTH];
        end
    end

    assign result_valid_o = out_valid;
    assign result_data_o  = out_data;
    assign frame_done_o   = out_valid && out_last && result_ready_i;

    a_hold : assert property (
        @(posedge clk) disable iff (rst)
        result_valid_o && !result_ready_i |=> result_valid_o && $stable(result_data_o)
    ) else $error("result changed while stalled");

endmodule

/* hdl/conv_top.sv */
// Convolution engine top level: feature-map bank, data setup and MAC chain
`timescale 1ns/1ns

module conv_top (
    input  logic                            clk,
    input  logic                            rst,

    // Feature map load, idle only
    input  logic                            wr_en_i,
    input  logic [conv_pkg::ADDR_WIDTH-1:0] wr_addr_i,
    input  conv_pkg::data_t                 wr_data_i,

    // Weight stream
    input  logic                            w_valid_i,
    input  conv_pkg::data_t                 w_data_i,
    output logic                            w_ready_o,

    input  logic                            start_i,
    input  logic [conv_pkg::SIZE_WIDTH-1:0] ofmap_size_i,

    // Result stream, row-major
    output logic                            result_valid_o,
    output conv_pkg::acc_t                  result_data_o,
    input  logic                            result_ready_i,
    output logic                            frame_done_o
);

    localparam int SRAM_DEPTH = conv_pkg::SRAM_DEPTH;
    localparam int BAND_WIDTH = conv_pkg::BAND_WIDTH;

    logic busy;

    bank_rd_if #(
        .BAND_WIDTH (BAND_WIDTH),
        .ADDR_WIDTH ($clog2(SRAM_DEPTH))
    ) rd_bus ();

    skew_if #(.BAND_WIDTH(BAND_WIDTH)) skew_bus ();

    ifmap_bank #(
        .SRAM_DEPTH (SRAM_DEPTH),
        .BAND_WIDTH (BAND_WIDTH)
    ) i_bank (
        .clk       (clk),
        .rst       (rst),
        .wr_en_i   (wr_en_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (wr_data_i),
        .rd        (rd_bus.server)
    );

    data_setup #(
        .SRAM_DEPTH (SRAM_DEPTH),
        .BAND_WIDTH (BAND_WIDTH)
    ) i_setup (
        .clk          (clk),
        .rst          (rst),
        .start_i      (start_i),
        .ofmap_size_i (ofmap_size_i),
        .busy_o       (busy),
        .rd           (rd_bus.client),
        .sa           (skew_bus.src)
    );

    mac_chain #(
        .BAND_WIDTH (BAND_WIDTH)
    ) i_chain (
        .clk            (clk),
        .rst            (rst),
        .busy_i         (busy),
        .w_valid_i      (w_valid_i),
        .w_data_i       (w_data_i),
        .w_ready_o      (w_ready_o),
        .sa             (skew_bus.snk),
        .result_valid_o (result_valid_o),
        .result_data_o  (result_data_o),
        .result_ready_i (result_ready_i),
        .frame_done_o   (frame_done_o)
    );

endmodule

/* verification/tb_checker.sv */
// Result checker that mirrors map and weights from the DUT ports and compares expected results
`timescale 1ns/1ns

module tb_checker (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [127:0]                    test_name_i,
    input  logic                            wr_en_i,
    input  logic [conv_pkg::ADDR_WIDTH-1:0] wr_addr_i,
    input  conv_pkg::data_t                 wr_data_i,
    input  logic                            w_valid_i,
    input  conv_pkg::data_t                 w_data_i,
    input  logic                            w_ready_i,
    input  logic                            start_i,
    input  logic [conv_pkg::SIZE_WIDTH-1:0] ofmap_size_i,
    input  logic                            result_valid_i,
    input  conv_pkg::acc_t                  result_data_i,
    input  logic                            result_ready_i,
    input  logic                            frame_done_i,
    output int                              err_cnt_o,
    output int                              tests_ok_o
);

    conv_pkg::data_t mem_mirror [conv_pkg::SRAM_DEPTH];
    conv_pkg::data_t wt_mirror [conv_pkg::BAND_WIDTH];
    int              expected_q [$];
    int              w_cnt;
    int              got;
    int              frame_len;
    int              frame_errs;
    logic            active;        // Start accepted and frame_done not yet seen

    task automatic count_error();
        err_cnt_o++;
        frame_errs++;
    endtask

    // Window sums over the mirrored map with input side equal to output side plus 2
    task automatic build_expected(input int size);
        int n;
        int acc;
        n = size + 2;
        expected_q.delete();
        for (int r = 0; r < size; r++) begin
            for (int c = 0; c < size; c++) begin
                acc = 0;
                for (int kr = 0; kr < 3; kr++) begin
                    for (int kc = 0; kc < 3; kc++) begin
                        acc += int'(mem_mirror[(r + kr) * n + c + kc])
                               * int'(wt_mirror[kr * 3 + kc]);
                    end
                end
                expected_q.push_back(acc);
            end
        end
    endtask

    task automatic check_result();
        int actual;
        int expected;
        actual = int'(result_data_i);
        if (expected_q.size() == 0) begin
            $display("ERROR %0s: more results than the expected %0d", test_name_i, frame_len);
            count_error();
        end else begin
            expected = expected_q.pop_front();
            got++;
            if (actual != expected) begin
                $display("MISMATCH %0s expected %0d actual %0d", test_name_i, expected, actual);
                count_error();
            end
            if (expected_q.size() == 0 && !frame_done_i) begin
                $display("ERROR %0s: last result accepted without frame_done_o", test_name_i);
                count_error();
            end
        end
        if (frame_done_i) begin
            if (expected_q.size() != 0) begin
                $display("ERROR %0s: frame_done_o after %0d of %0d results",
                         test_name_i, got, frame_len);
                count_error();
            end
            $display("%0s: %0d results checked, %0d errors", test_name_i, got, frame_errs);
            if (frame_errs == 0) begin
                tests_ok_o++;
            end
            active = 1'b0;
        end
    endtask

    always @(posedge clk) begin
        if (rst) begin
            err_cnt_o  = 0;
            tests_ok_o = 0;
            w_cnt      = 0;
            got        = 0;
            frame_len  = 0;
            frame_errs = 0;
            active     = 1'b0;
            expected_q.delete();
        end else begin
            if (wr_en_i) begin
                mem_mirror[wr_addr_i] = wr_data_i;
            end
            if (w_valid_i && w_ready_i) begin
                wt_mirror[w_cnt] = w_data_i;   // Index 0 arrives first
                w_cnt = (w_cnt + 1) % conv_pkg::BAND_WIDTH;
            end
            if (active && w_ready_i) begin
                $display("ERROR %0s: w_ready_o high while a frame is running", test_name_i);
                count_error();
            end
            if (result_valid_i && !active) begin
                $display("ERROR %0s: result_valid_o high while the engine is idle", test_name_i);
                count_error();
            end
            if (frame_done_i && !(result_valid_i && result_ready_i && active)) begin
                $display("ERROR %0s: frame_done_o high with no result accepted", test_name_i);
                count_error();
            end
            if (result_valid_i && result_ready_i && active) begin
                check_result();
            end
            if (start_i && w_ready_i) begin
                build_expected(int'(ofmap_size_i));
                frame_len  = int'(ofmap_size_i) * int'(ofmap_size_i);
                got        = 0;
                frame_errs = 0;
                w_cnt      = 0;
                active     = 1'b1;
            end
        end
    end

endmodule

/* verification/tb_top.sv */
// Testbench top: clock, reset, stimulus table, LCG, driver loop and cycle timeout
`timescale 1ns/1ns

module tb_top;

    localparam logic [1:0] MODE_RAND  = 2'd0;
    localparam logic [1:0] MODE_ONES  = 2'd1;
    localparam logic [1:0] MODE_MIXED = 2'd2;   // -128 or 127 by address parity
    localparam logic [1:0] MODE_MIN   = 2'd3;   // All -128

    localparam logic [1:0] RDY_ALWAYS = 2'd0;
    localparam logic [1:0] RDY_RANDOM = 2'd1;
    localparam logic [1:0] RDY_SLOW   = 2'd2;   // Ready one cycle in three

    typedef struct packed {
        logic [127:0] name;
        logic [3:0]   size;
        logic [1:0]   pix_mode;
        logic [1:0]   wt_mode;
        logic [1:0]   rdy_mode;
    } test_t;

    localparam int NUM_TESTS = 7;
    localparam test_t TESTS [NUM_TESTS] = '{
        '{"ones_win_4",  4'd4,  MODE_RAND,  MODE_ONES,  RDY_ALWAYS},
        '{"rand_14",     4'd14, MODE_RAND,  MODE_RAND,  RDY_ALWAYS},
        '{"rand_14_bp",  4'd14, MODE_RAND,  MODE_RAND,  RDY_RANDOM},
        '{"extreme_5",   4'd5,  MODE_MIXED, MODE_MIXED, RDY_SLOW},
        '{"min_3",       4'd3,  MODE_MIN,   MODE_MIN,   RDY_ALWAYS},
        '{"size_1",      4'd1,  MODE_RAND,  MODE_RAND,  RDY_RANDOM},
        '{"reload_6",    4'd6,  MODE_RAND,  MODE_RAND,  RDY_RANDOM}
    };

    logic                            clk;
    logic                            rst;
    logic                            wr_en;
    logic [conv_pkg::ADDR_WIDTH-1:0] wr_addr;
    conv_pkg::data_t                 wr_data;
    logic                            w_valid;
    conv_pkg::data_t                 w_data;
    logic                            w_ready;
    logic                            start;
    logic [conv_pkg::SIZE_WIDTH-1:0] ofmap_size;
    logic                            result_valid;
    conv_pkg::acc_t                  result_data;
    logic                            result_ready;
    logic                            frame_done;
    logic [127:0]                    cur_name;
    logic [31:0]                     lcg_state;
    int                              err_cnt;
    int                              tests_ok;
    int                              cycle_cnt;
    int                              timeout_limit;

    conv_top i_dut (
        .clk (clk), .rst (rst),
        .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .w_valid_i (w_valid), .w_data_i (w_data), .w_ready_o (w_ready),
        .start_i (start), .ofmap_size_i (ofmap_size),
        .result_valid_o (result_valid), .result_data_o (result_data),
        .result_ready_i (result_ready), .frame_done_o (frame_done)
    );

    tb_checker i_chk (
        .clk (clk), .rst (rst), .test_name_i (cur_name),
        .wr_en_i (wr_en), .wr_addr_i (wr_addr), .wr_data_i (wr_data),
        .w_valid_i (w_valid), .w_data_i (w_data), .w_ready_i (w_ready),
        .start_i (start), .ofmap_size_i (ofmap_size),
        .result_valid_i (result_valid), .result_data_i (result_data),
        .result_ready_i (result_ready), .frame_done_i (frame_done),
        .err_cnt_o (err_cnt), .tests_ok_o (tests_ok)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [7:0] lcg_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];   // Middle bits, low ones cycle too fast
    endfunction

    function automatic conv_pkg::data_t fill_value(input logic [1:0] mode, input logic [7:0] idx);
        case (mode)
            MODE_ONES:  return conv_pkg::data_t'(1);
            MODE_MIXED: return (^idx) ? conv_pkg::data_t'(-128) : conv_pkg::data_t'(127);
            MODE_MIN:   return conv_pkg::data_t'(-128);
            default:    return conv_pkg::data_t'(lcg_byte());
        endcase
    endfunction

    function automatic logic ready_value(input logic [1:0] mode, input int cyc);
        case (mode)
            RDY_RANDOM: return lcg_byte() < 8'd150;
            RDY_SLOW:   return (cyc % 3) == 0;
            default:    return 1'b1;
        endcase
    endfunction

    // Four times results, latency allowance and map writes, per test
    function automatic int cycle_budget();
        int total;
        int s;
        total = 0;
        for (int t = 0; t < NUM_TESTS; t++) begin
            s = int'(TESTS[t].size);
            total += 4 * (s * s + 40 + (s + 2) * (s + 2));
        end
        return total;
    endfunction

    task automatic load_map(input logic [3:0] size, input logic [1:0] mode);
        int n;
        n = int'(size) + 2;
        for (int a = 0; a < n * n; a++) begin
            @(negedge clk);
            wr_en   = 1'b1;
            wr_addr = conv_pkg::ADDR_WIDTH'(a);
            wr_data = fill_value(mode, 8'(a));
        end
        @(negedge clk);
        wr_en = 1'b0;
    endtask

    task automatic load_weights(input logic [1:0] mode);
        for (int i = 0; i < conv_pkg::BAND_WIDTH; i++) begin
            @(negedge clk);
            w_valid = 1'b1;
            w_data  = fill_value(mode, 8'(i));
            @(posedge clk);
            while (!w_ready) @(posedge clk);
        end
        @(negedge clk);
        w_valid = 1'b0;
    endtask

    task automatic start_frame(input logic [3:0] size);
        @(negedge clk);
        start      = 1'b1;
        ofmap_size = size;
        @(negedge clk);
        start = 1'b0;
    endtask

    task automatic drain_results(input logic [1:0] mode);
        int cyc;
        cyc = 0;
        do begin
            @(negedge clk);
            result_ready = ready_value(mode, cyc);
            cyc++;
            @(posedge clk);
        end while (!frame_done);
        @(negedge clk);
        result_ready = 1'b0;   // Name changes only away from the sampling edge
    endtask

    // Ends the run if the tests take longer than the budget
    initial begin
        timeout_limit = cycle_budget();
        cycle_cnt = 0;
        while (cycle_cnt < timeout_limit) begin
            @(posedge clk);
            cycle_cnt++;
        end
        $display("Timeout: run still going after %0d cycles", cycle_cnt);
        $display("Finished with errors");
        $finish;
    end

    initial begin
        rst          = 1'b1;
        wr_en        = 1'b0;
        wr_addr      = '0;
        wr_data      = '0;
        w_valid      = 1'b0;
        w_data       = '0;
        start        = 1'b0;
        ofmap_size   = '0;
        result_ready = 1'b0;
        cur_name     = '0;
        lcg_state    = 32'd49227;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        for (int t = 0; t < NUM_TESTS; t++) begin
            cur_name = TESTS[t].name;
            load_map(TESTS[t].size, TESTS[t].pix_mode);
            load_weights(TESTS[t].wt_mode);
            start_frame(TESTS[t].size);
            drain_results(TESTS[t].rdy_mode);
        end
        repeat (4) @(posedge clk);

        $display("Tests passed: %0d of %0d, errors: %0d", tests_ok, NUM_TESTS, err_cnt);
        if (err_cnt == 0 && tests_ok == NUM_TESTS) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* compile.f */
hdl/conv_pkg.sv
hdl/conv_ifs.sv
hdl/ifmap_bank.sv
hdl/data_setup.sv
hdl/mac_pe.sv
hdl/mac_chain.sv
hdl/conv_top.sv
verification/tb_checker.sv
verification/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the convolution engine testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_top \
    -f compile.f \
    --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb > sim.log
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation completed cleanly"
